// ==== verilog/pce_io_pkg.sv ====
// Shared types for the console I/O block.
// Pads, audio samples and backup RAM addressing, used by scoped name.

package pce_io_pkg;

	// ==============================
	// Controller side
	// ==============================

	// Active high, 3..0 directions, 7..4 main, 11..8 six-button extras
	typedef logic [11:0] pad_bits_t;

	typedef struct packed {
		pad_bits_t pad0;
		pad_bits_t pad1;
		pad_bits_t pad2;
		pad_bits_t pad3;
		pad_bits_t pad4;
	} pad_set_t;

	typedef struct packed {
		logic joy_swap;   // Swap players 1 and 2
		logic turbotap;   // Multitap on port
		logic six_button;
		logic mouse_en;   // Mouse replaces pad 0
	} io_config_t;

	typedef logic [3:0] nibble_t; // One read of the controller port

	// ==============================
	// Audio
	// ==============================
	typedef logic signed [19:0] psg_sample_t; // PSG and CD-DA
	typedef logic signed [15:0] adpcm_sample_t;
	typedef logic signed [19:0] mix_sample_t;

	typedef struct packed {
		psg_sample_t   psg_l;
		psg_sample_t   psg_r;
		psg_sample_t   cdda_l;
		psg_sample_t   cdda_r;
		adpcm_sample_t adpcm; // Mono, feeds both sides
	} audio_in_t;

	// ==============================
	// Backup RAM
	// ==============================
	typedef logic [10:0] bram_addr_t;  // 2 KiB console window
	typedef logic [8:0]  sector_addr_t; // Byte within a 512 byte sector

	localparam int BACKUP_SECTORS = 4;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_REQ,      // Request up, waiting for ack
		BK_WAIT_END  // Sector moving, waiting for ack to drop
	} bk_state_t;

endpackage

// ==== verilog/pad_mux.sv ====
// Controller port multiplexer.
// Builds the 16-bit button word of the selected port and returns the
// nibble picked by sel and the six-button bank, with multitap support.

module pad_mux (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  pce_io_pkg::pad_set_t   pads,
	input  pce_io_pkg::io_config_t io_cfg,
	input  logic [1:0]             joy_out,       // Bit 0 sel, bit 1 clr
	input  logic [7:0]             mouse_nibbles,
	output pce_io_pkg::nibble_t    joy_in
);

	pce_io_pkg::pad_bits_t joy_0;
	pce_io_pkg::pad_bits_t joy_1;
	logic [15:0] pad_word;
	logic [2:0]  port_cnt;
	logic        high_bank;
	logic [1:0]  last_out;

	// Console order, all active low, top nibble unused
	function automatic logic [15:0] to_word(input pce_io_pkg::pad_bits_t p);
		return ~{4'hF, p[11:8], p[1], p[2], p[0], p[3], p[7:4]};
	endfunction

	assign joy_0 = io_cfg.joy_swap ? pads.pad1 : pads.pad0;
	assign joy_1 = io_cfg.joy_swap ? pads.pad0 : pads.pad1;

	always_comb begin
		case (port_cnt)
			3'd0:    pad_word = io_cfg.mouse_en ? {mouse_nibbles, mouse_nibbles} : to_word(joy_0);
			3'd1:    pad_word = to_word(joy_1);
			3'd2:    pad_word = to_word(pads.pad2);
			3'd3:    pad_word = to_word(pads.pad3);
			3'd4:    pad_word = to_word(pads.pad4);
			default: pad_word = 16'h0FFF; // Empty multitap ports
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			joy_in    <= '0;
			port_cnt  <= '0;
			high_bank <= 1'b0;
			last_out  <= '0;
		end else begin
			last_out <= joy_out;
			joy_in   <= pad_word[{high_bank, joy_out[0], 2'b00} +: 4];

			if (joy_out[1]) begin
				port_cnt <= '0;
				joy_in   <= '0;
				// Each clr alternates banks on a six-button pad
				if (!last_out[1])
					high_bank <= ~high_bank & io_cfg.six_button;
			end else if (joy_out[0] && !last_out[0] && io_cfg.turbotap) begin
				if (port_cnt != 3'd7)
					port_cnt <= port_cnt + 3'd1; // Next multitap port
			end
		end
	end

	// Console sees an all-zero read right after clearing the tap
	a_clr_zero: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		joy_out[1] |=> (joy_in == '0)
	);

endmodule

// ==== verilog/mouse_reader.sv ====
// Mouse reader for the controller port.
// Captures motion on each host strobe and presents it to the console as a
// sequence of four nibbles, one per rising clr, with an idle resync.

module mouse_reader #(
	parameter int MOUSE_TIMEOUT_W = 15
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [1:0] joy_out,
	input  logic [7:0] mouse_x,
	input  logic [7:0] mouse_y,
	input  logic [1:0] mouse_btn,
	input  logic       mouse_strobe,
	input  logic [1:0] main_buttons, // Pad 0 bits 7..6 after swap
	output logic [7:0] mouse_nibbles
);

	logic                       last_clr;
	logic [MOUSE_TIMEOUT_W-1:0] idle_cnt;
	logic [1:0]                 nib_cnt;
	logic [7:0]                 acc_x;
	logic [7:0]                 acc_y;
	logic [7:0]                 shown_x;
	logic [7:0]                 shown_y;
	logic                       clr_rise;

	assign clr_rise = joy_out[1] & ~last_clr;

	always_comb begin
		// Buttons always sit in the low nibble
		mouse_nibbles[3:0] = ~{main_buttons, mouse_btn[0], mouse_btn[1]};
		case (nib_cnt)
			2'd0: mouse_nibbles[7:4] = shown_x[7:4];
			2'd1: mouse_nibbles[7:4] = shown_x[3:0];
			2'd2: mouse_nibbles[7:4] = shown_y[7:4];
			default: mouse_nibbles[7:4] = shown_y[3:0];
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			last_clr <= 1'b0;
			idle_cnt <= '0;
			nib_cnt  <= '0;
			acc_x    <= '0;
			acc_y    <= '0;
			shown_x  <= '0;
			shown_y  <= '0;
		end else begin
			last_clr <= joy_out[1];

			if (joy_out[1])
				idle_cnt <= '0;
			else if (!(&idle_cnt))
				idle_cnt <= idle_cnt + 1'b1;

			// Console gave up mid-sequence, next clr starts at x high
			if (&idle_cnt)
				nib_cnt <= 2'd3;

			if (clr_rise) begin
				nib_cnt <= nib_cnt + 2'd1;
				if (&nib_cnt) begin
					shown_x <= acc_x;
					shown_y <= acc_y;
					acc_x   <= '0;
					acc_y   <= '0;
				end
			end

			if (mouse_strobe) begin
				acc_x <= 8'd0 - mouse_x; // Console x axis runs the other way
				acc_y <= mouse_y;
			end
		end
	end

endmodule

// ==== verilog/audio_mixer.sv ====
// Stereo audio mixer.
// Adds PSG, CD-DA and ADPCM in 22 bits and clamps to a 20-bit sample.

module audio_mixer (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  pce_io_pkg::audio_in_t   audio_in,
	output pce_io_pkg::mix_sample_t audio_l,
	output pce_io_pkg::mix_sample_t audio_r
);

	logic signed [21:0] adpcm_ext;
	logic signed [21:0] sum_l;
	logic signed [21:0] sum_r;

	function automatic logic signed [21:0] ext20(input pce_io_pkg::psg_sample_t s);
		return {{2{s[19]}}, s};
	endfunction

	// Clamp to the 20-bit range when the top three bits disagree
	function automatic pce_io_pkg::mix_sample_t sat20(input logic signed [21:0] s);
		if (s[21:19] == 3'b000 || s[21:19] == 3'b111)
			return s[19:0];
		return s[21] ? 20'sh80000 : 20'sh7FFFF;
	endfunction

	assign adpcm_ext = {{2{audio_in.adpcm[15]}}, audio_in.adpcm, 4'b0000}; // x16

	assign sum_l = ext20(audio_in.psg_l) + ext20(audio_in.cdda_l) + adpcm_ext;
	assign sum_r = ext20(audio_in.psg_r) + ext20(audio_in.cdda_r) + adpcm_ext;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= sat20(sum_l);
			audio_r <= sat20(sum_r);
		end
	end

	a_quiet_in_reset: assert property (
		@(posedge clk_sys)
		(!rst_n ##1 !rst_n) |=> ($stable(audio_l) && $stable(audio_r))
	);

endmodule

// ==== verilog/backup_ram.sv ====
// Backup RAM with save image transfer.
// Console port on one side, host sector buffer on the other. Mounting an
// image loads all sectors and resets the console, bk_save writes them back.

module backup_ram (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  pce_io_pkg::bram_addr_t   brm_addr,
	input  logic [7:0]               brm_wdata,
	input  logic                     brm_we,
	output logic [7:0]               brm_rdata,
	input  logic                     img_mounted,
	input  logic                     img_size_nz,
	input  logic                     bk_save,
	input  logic                     sd_ack,
	input  pce_io_pkg::sector_addr_t sd_buff_addr,
	input  logic [7:0]               sd_buff_dout,
	input  logic                     sd_buff_wr,
	output logic [$clog2(pce_io_pkg::BACKUP_SECTORS)-1:0] sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic [7:0]               sd_buff_din,
	output logic                     bk_reset,
	output logic                     bk_active
);

	logic [7:0] mem [0:2**$bits(pce_io_pkg::bram_addr_t)-1];

	pce_io_pkg::bram_addr_t host_addr;
	pce_io_pkg::bk_state_t  state;
	logic old_mounted;
	logic old_save;
	logic old_ack;
	logic armed;    // Save image present
	logic is_load;  // Direction of the running transfer
	logic start_load;
	logic start_save;

	// ==============================
	// Dual-port array
	// ==============================
	assign host_addr = {sd_lba, sd_buff_addr};

	always @(posedge clk_sys) begin
		if (brm_we)
			mem[brm_addr] <= brm_wdata;
		brm_rdata <= mem[brm_addr];
	end

	always @(posedge clk_sys) begin
		if (sd_buff_wr && sd_ack)
			mem[host_addr] <= sd_buff_dout; // Host fills during load
		sd_buff_din <= mem[host_addr];
	end

	// ==============================
	// Sector sequencer
	// ==============================
	assign start_load = img_mounted & ~old_mounted & img_size_nz;
	assign start_save = bk_save & ~old_save & armed;
	assign bk_active  = (state != pce_io_pkg::BK_IDLE);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state       <= pce_io_pkg::BK_IDLE;
			old_mounted <= 1'b0;
			old_save    <= 1'b0;
			old_ack     <= 1'b0;
			armed       <= 1'b0;
			is_load     <= 1'b0;
			sd_lba      <= '0;
			sd_rd       <= 1'b0;
			sd_wr       <= 1'b0;
			bk_reset    <= 1'b0;
		end else begin
			old_mounted <= img_mounted;
			old_save    <= bk_save;
			old_ack     <= sd_ack;
			bk_reset    <= 1'b0;

			if (start_load)
				armed <= 1'b1;

			case (state)
				pce_io_pkg::BK_IDLE: begin
					if (start_load || start_save) begin
						is_load <= start_load; // Load wins a tie
						sd_lba  <= '0;
						sd_rd   <= start_load;
						sd_wr   <= ~start_load;
						state   <= pce_io_pkg::BK_REQ;
					end
				end
				pce_io_pkg::BK_REQ: begin
					if (sd_ack && !old_ack) begin // Host took the request
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= pce_io_pkg::BK_WAIT_END;
					end
				end
				pce_io_pkg::BK_WAIT_END: begin
					if (!sd_ack && old_ack) begin
						if (sd_lba == pce_io_pkg::BACKUP_SECTORS - 1) begin
							bk_reset <= is_load; // Restart console on fresh data
							state    <= pce_io_pkg::BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= is_load;
							sd_wr  <= ~is_load;
							state  <= pce_io_pkg::BK_REQ;
						end
					end
				end
				default: state <= pce_io_pkg::BK_IDLE;
			endcase
		end
	end

	a_one_dir: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!(sd_rd && sd_wr)
	);

endmodule

// ==== verilog/pce_io_top.sv ====
// Console I/O top level.
// Ties together the pad port, mouse reader, audio mixer and backup RAM.

module pce_io_top #(
	parameter int MOUSE_TIMEOUT_W = 15 // Mouse idle counter width
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,

	// Controllers
	input  pce_io_pkg::pad_set_t     pads,
	input  pce_io_pkg::io_config_t   io_cfg,
	input  logic [1:0]               joy_out,
	output pce_io_pkg::nibble_t      joy_in,
	input  logic [7:0]               mouse_x,
	input  logic [7:0]               mouse_y,
	input  logic [1:0]               mouse_btn,
	input  logic                     mouse_strobe,

	// Audio
	input  pce_io_pkg::audio_in_t    audio_in,
	output pce_io_pkg::mix_sample_t  audio_l,
	output pce_io_pkg::mix_sample_t  audio_r,

	// Console backup port
	input  pce_io_pkg::bram_addr_t   brm_addr,
	input  logic [7:0]               brm_wdata,
	input  logic                     brm_we,
	output logic [7:0]               brm_rdata,

	// Host sector port
	input  logic                     img_mounted,
	input  logic                     img_size_nz,
	input  logic                     bk_save,
	input  logic                     sd_ack,
	input  pce_io_pkg::sector_addr_t sd_buff_addr,
	input  logic [7:0]               sd_buff_dout,
	input  logic                     sd_buff_wr,
	output logic [1:0]               sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic [7:0]               sd_buff_din,
	output logic                     bk_reset,
	output logic                     bk_active
);

	logic [7:0] mouse_nibbles;
	logic [1:0] main_buttons;

	// Player 1 buttons I and II share the mouse read
	assign main_buttons = io_cfg.joy_swap ? pads.pad1[7:6] : pads.pad0[7:6];

	pad_mux u_pad_mux (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.pads          (pads),
		.io_cfg        (io_cfg),
		.joy_out       (joy_out),
		.mouse_nibbles (mouse_nibbles),
		.joy_in        (joy_in)
	);

	mouse_reader #(
		.MOUSE_TIMEOUT_W (MOUSE_TIMEOUT_W)
	) u_mouse_reader (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.joy_out       (joy_out),
		.mouse_x       (mouse_x),
		.mouse_y       (mouse_y),
		.mouse_btn     (mouse_btn),
		.mouse_strobe  (mouse_strobe),
		.main_buttons  (main_buttons),
		.mouse_nibbles (mouse_nibbles)
	);

	audio_mixer u_audio_mixer (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.audio_in (audio_in),
		.audio_l  (audio_l),
		.audio_r  (audio_r)
	);

	backup_ram u_backup_ram (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.brm_addr     (brm_addr),
		.brm_wdata    (brm_wdata),
		.brm_we       (brm_we),
		.brm_rdata    (brm_rdata),
		.img_mounted  (img_mounted),
		.img_size_nz  (img_size_nz),
		.bk_save      (bk_save),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_buff_din  (sd_buff_din),
		.bk_reset     (bk_reset),
		.bk_active    (bk_active)
	);

endmodule

// ==== dv/tb_checker.sv ====
// Result checker for the console I/O testbench.
// Holds the reference models, compares the mixer on every cycle and the
// other outputs when the stimulus asks, and keeps the per-test counts.

module tb_checker (
	input logic                    clk_sys,
	input logic                    rst_n,
	input pce_io_pkg::pad_set_t    pads,
	input pce_io_pkg::io_config_t  io_cfg,
	input pce_io_pkg::nibble_t     joy_in,
	input logic [1:0]              mouse_btn,
	input pce_io_pkg::audio_in_t   audio_in,
	input pce_io_pkg::mix_sample_t audio_l,
	input pce_io_pkg::mix_sample_t audio_r,
	input logic                    bk_reset
);
	timeunit 1ns;
	timeprecision 1ps;

	int test_checks  = 0;
	int test_errors  = 0;
	int total_errors = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int sat_hi       = 0;
	int sat_lo       = 0;
	int reset_pulses = 0;

	pce_io_pkg::audio_in_t prev_in;
	logic                  prev_rst = 1'b0;

	// ==============================
	// Reference models
	// ==============================
	function automatic int mix_ref(input int a, input int b, input int adpcm);
		int s;
		s = a + b + adpcm * 16;
		if (s > 524287)
			return 524287;
		if (s < -524288)
			return -524288;
		return s;
	endfunction

	// One nibble of a pad, active low
	function automatic pce_io_pkg::nibble_t pad_nibble(input pce_io_pkg::pad_bits_t p,
			input bit bank, input bit sel);
		case ({bank, sel})
			2'b00:   return ~p[7:4];
			2'b01:   return ~{p[1], p[2], p[0], p[3]}; // Direction order of the port
			2'b10:   return ~p[11:8];
			default: return 4'h0;
		endcase
	endfunction

	function automatic logic [7:0] mouse_ref(input int cnt, input logic [7:0] x,
			input logic [7:0] y, input logic [1:0] btn, input logic [1:0] main);
		logic [3:0] hi;
		case (cnt)
			0:       hi = x[7:4];
			1:       hi = x[3:0];
			2:       hi = y[7:4];
			default: hi = y[3:0];
		endcase
		return {hi, ~{main, btn[0], btn[1]}};
	endfunction

	// ==============================
	// Compare helpers
	// ==============================
	task automatic check_value(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		test_checks++;
		if (got !== exp) begin
			test_errors++;
			$display("[FAIL] %s: got %h expected %h", sig, got, exp);
		end
	endtask

	task automatic require(input bit ok, input string what);
		test_checks++;
		if (!ok) begin
			test_errors++;
			$display("Error: %s", what);
		end
	endtask

	task automatic check_pad(input int port, input bit bank, input bit sel);
		pce_io_pkg::pad_bits_t p;
		pce_io_pkg::nibble_t   exp;
		case (port)
			0:       p = io_cfg.joy_swap ? pads.pad1 : pads.pad0;
			1:       p = io_cfg.joy_swap ? pads.pad0 : pads.pad1;
			2:       p = pads.pad2;
			3:       p = pads.pad3;
			default: p = pads.pad4;
		endcase
		if (port >= 5)
			exp = (bank && sel) ? 4'h0 : 4'hF; // Empty tap port
		else
			exp = pad_nibble(p, bank, sel);
		check_value("joy_in", joy_in, exp);
	endtask

	task automatic check_mouse(input int cnt, input logic [7:0] x, input logic [7:0] y,
			input bit sel);
		logic [1:0] main;
		logic [7:0] m;
		main = io_cfg.joy_swap ? pads.pad1[7:6] : pads.pad0[7:6];
		m = mouse_ref(cnt, x, y, mouse_btn, main);
		check_value("joy_in", joy_in, sel ? m[7:4] : m[3:0]);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("Test %-14s %s  (%0d checks, %0d errors)", name,
			(test_errors == 0) ? "ok" : "bad", test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic report_counts();
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors);
	endtask

	// Mixer output against the input of the cycle before
	always @(posedge clk_sys) begin
		pce_io_pkg::mix_sample_t exp_l;
		pce_io_pkg::mix_sample_t exp_r;
		int                      l;
		int                      r;
		if (rst_n && prev_rst) begin
			l = mix_ref(prev_in.psg_l, prev_in.cdda_l, prev_in.adpcm);
			r = mix_ref(prev_in.psg_r, prev_in.cdda_r, prev_in.adpcm);
			exp_l = 20'(l);
			exp_r = 20'(r);
			if (l == 524287 || r == 524287)
				sat_hi++;
			if (l == -524288 || r == -524288)
				sat_lo++;
			check_value("audio_l", 32'(audio_l), 32'(exp_l));
			check_value("audio_r", 32'(audio_r), 32'(exp_r));
		end
		if (rst_n && bk_reset)
			reset_pulses++;
		prev_in  <= audio_in;
		prev_rst <= rst_n;
	end

endmodule

// ==== dv/tb_top.sv ====
// Testbench top for the console I/O block.
// Generates clock and reset, drives the pad, mouse, audio and backup ports,
// and plays the host side of the sector transfers. tb_checker does the comparing.

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	// Rough cycle budget per test
	localparam int AUDIO_CYC = 250;
	localparam int PAD_CYC   = 150;
	localparam int TAP_CYC   = 100;
	localparam int MOUSE_CYC = 400;
	localparam int LOAD_CYC  = 4 * 520 + 2 * 2048 + 200;
	localparam int SAVE_CYC  = 2048 + 4 * (2 * 512 + 20) + 200;
	localparam int CYC_LIMIT =
		(AUDIO_CYC + PAD_CYC + TAP_CYC + MOUSE_CYC + LOAD_CYC + SAVE_CYC) * 3 / 2;

	logic                     clk_sys = 1'b0;
	logic                     rst_n;
	pce_io_pkg::pad_set_t     pads;
	pce_io_pkg::io_config_t   io_cfg;
	logic [1:0]               joy_out;
	pce_io_pkg::nibble_t      joy_in;
	logic [7:0]               mouse_x;
	logic [7:0]               mouse_y;
	logic [1:0]               mouse_btn;
	logic                     mouse_strobe;
	pce_io_pkg::audio_in_t    audio_in;
	pce_io_pkg::mix_sample_t  audio_l;
	pce_io_pkg::mix_sample_t  audio_r;
	pce_io_pkg::bram_addr_t   brm_addr;
	logic [7:0]               brm_wdata;
	logic                     brm_we;
	logic [7:0]               brm_rdata;
	logic                     img_mounted;
	logic                     img_size_nz;
	logic                     bk_save;
	logic                     sd_ack;
	pce_io_pkg::sector_addr_t sd_buff_addr;
	logic [7:0]               sd_buff_dout;
	logic                     sd_buff_wr;
	logic [1:0]               sd_lba;
	logic                     sd_rd;
	logic                     sd_wr;
	logic [7:0]               sd_buff_din;
	logic                     bk_reset;
	logic                     bk_active;

	logic [7:0] load_data [0:2047];
	logic [7:0] save_data [0:2047];
	int         cycles = 0;

	always #4 clk_sys = ~clk_sys;

	pce_io_top #(
		.MOUSE_TIMEOUT_W (6)
	) u_dut (.*);

	tb_checker u_chk (.*);

	// ==============================
	// Stimulus helpers
	// ==============================
	function automatic pce_io_pkg::pad_set_t rand_pads();
		pce_io_pkg::pad_set_t p;
		p.pad0 = 12'($urandom());
		p.pad1 = 12'($urandom());
		p.pad2 = 12'($urandom());
		p.pad3 = 12'($urandom());
		p.pad4 = 12'($urandom());
		return p;
	endfunction

	function automatic pce_io_pkg::audio_in_t rand_audio();
		pce_io_pkg::audio_in_t a;
		a.psg_l  = 20'($urandom());
		a.psg_r  = 20'($urandom());
		a.cdda_l = 20'($urandom());
		a.cdda_r = 20'($urandom());
		a.adpcm  = 16'($urandom());
		return a;
	endfunction

	// New joy_out value, returns once joy_in reflects it
	task automatic set_joy(input logic [1:0] v);
		@(posedge clk_sys);
		joy_out <= v;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic strobe_mouse(input logic [7:0] x, input logic [7:0] y);
		@(posedge clk_sys);
		mouse_x      <= x;
		mouse_y      <= y;
		mouse_strobe <= 1'b1;
		@(posedge clk_sys);
		mouse_strobe <= 1'b0;
	endtask

	// Host waits for a sector request of the given direction
	task automatic wait_request(input bit is_write, input int sector);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (!(is_write ? sd_wr : sd_rd) && n < 100);
		u_chk.require(n < 100, "no sector request from the backup RAM");
		u_chk.check_value("sd_lba", sd_lba, sector);
		u_chk.check_value("bk_active", bk_active, 1);
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (bk_active && n < 100) begin
			@(negedge clk_sys);
			n++;
		end
		u_chk.require(!bk_active, "backup transfer never finished");
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		bit b;
		logic [7:0] sx;
		logic [7:0] sy;

		void'($urandom(32'h3342));
		rst_n        = 1'b0;
		pads         = '0;
		io_cfg       = '0;
		joy_out      = '0;
		mouse_x      = '0;
		mouse_y      = '0;
		mouse_btn    = '0;
		mouse_strobe = 1'b0;
		audio_in     = '0;
		brm_addr     = '0;
		brm_wdata    = '0;
		brm_we       = 1'b0;
		img_mounted  = 1'b0;
		img_size_nz  = 1'b0;
		bk_save      = 1'b0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;

		// Audio, the checker compares every cycle
		for (int i = 0; i < 200; i++) begin
			@(posedge clk_sys);
			if (i == 0)
				audio_in <= {20'sh7FFFF, 20'sh7FFFF, 20'sh7FFFF, 20'sh7FFFF, 16'sh7FFF};
			else if (i == 1)
				audio_in <= {20'sh80000, 20'sh80000, 20'sh80000, 20'sh80000, 16'sh8000};
			else
				audio_in <= rand_audio();
		end
		repeat (2) @(posedge clk_sys);
		u_chk.require(u_chk.sat_hi > 0 && u_chk.sat_lo > 0,
			"audio saturation limits were not both reached");
		u_chk.finish_test("audio mixing");

		// Single pad, swapped, six buttons then two
		@(posedge clk_sys);
		io_cfg <= '{joy_swap: 1'b1, turbotap: 1'b0, six_button: 1'b1, mouse_en: 1'b0};
		pads   <= rand_pads();
		b = 1'b0;
		for (int r = 0; r < 6; r++) begin
			if (r == 3) begin
				@(posedge clk_sys);
				io_cfg.six_button <= 1'b0;
			end
			set_joy(2'b10);
			u_chk.check_value("joy_in", joy_in, 0);
			b = (r < 3) ? ~b : 1'b0; // Bank flips only on six-button pads
			set_joy(2'b00);
			u_chk.check_pad(0, b, 1'b0);
			set_joy(2'b01);
			u_chk.check_pad(0, b, 1'b1);
		end
		u_chk.finish_test("single pad");

		// Multitap walk through all eight ports
		@(posedge clk_sys);
		io_cfg <= '{joy_swap: 1'b0, turbotap: 1'b1, six_button: 1'b0, mouse_en: 1'b0};
		pads   <= rand_pads();
		set_joy(2'b10);
		u_chk.check_value("joy_in", joy_in, 0);
		for (int p = 0; p < 8; p++) begin
			set_joy(2'b00);
			u_chk.check_pad(p, 1'b0, 1'b0);
			set_joy(2'b01);
			u_chk.check_pad(p, 1'b0, 1'b1); // Port moves on after this read
		end
		u_chk.finish_test("multitap");

		// Mouse, start from the idle resync state
		@(posedge clk_sys);
		io_cfg    <= '{joy_swap: 1'b0, turbotap: 1'b0, six_button: 1'b0, mouse_en: 1'b1};
		mouse_btn <= 2'($urandom());
		set_joy(2'b01);
		repeat (70) @(posedge clk_sys);
		sy = 8'($urandom());
		sx = 8'($urandom());
		strobe_mouse(sx, sy);
		sx = 8'd0 - sx;
		for (int c = 0; c < 4; c++) begin
			set_joy(2'b10);
			set_joy(2'b00);
			u_chk.check_mouse(c, sx, sy, 1'b0);
			set_joy(2'b01);
			u_chk.check_mouse(c, sx, sy, 1'b1);
		end
		sy = 8'($urandom());
		sx = 8'($urandom());
		strobe_mouse(sx, sy);
		sx = 8'd0 - sx;
		set_joy(2'b10);
		set_joy(2'b01);
		u_chk.check_mouse(0, sx, sy, 1'b1);
		repeat (70) @(posedge clk_sys);
		@(negedge clk_sys);
		u_chk.check_mouse(3, sx, sy, 1'b1); // Timed out, back at count 3
		sy = 8'($urandom());
		sx = 8'($urandom());
		strobe_mouse(sx, sy);
		sx = 8'd0 - sx;
		set_joy(2'b10);
		set_joy(2'b01);
		u_chk.check_mouse(0, sx, sy, 1'b1);
		u_chk.finish_test("mouse");

		// Load from a mounted save image
		for (int a = 0; a < 2048; a++)
			load_data[a] = 8'($urandom());
		@(posedge clk_sys);
		img_size_nz <= 1'b1;
		img_mounted <= 1'b1;
		for (int s = 0; s < 4; s++) begin
			wait_request(1'b0, s);
			@(posedge clk_sys);
			sd_ack <= 1'b1;
			for (int i = 0; i < 512; i++) begin
				@(posedge clk_sys);
				sd_buff_addr <= 9'(i);
				sd_buff_dout <= load_data[s * 512 + i];
				sd_buff_wr   <= 1'b1;
			end
			@(posedge clk_sys);
			sd_buff_wr <= 1'b0;
			sd_ack     <= 1'b0;
		end
		wait_idle();
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		for (int a = 0; a < 2048; a++) begin
			@(posedge clk_sys);
			brm_addr <= 11'(a);
			@(posedge clk_sys);
			@(negedge clk_sys);
			u_chk.check_value("brm_rdata", brm_rdata, load_data[a]);
		end
		u_chk.check_value("bk_reset pulses", u_chk.reset_pulses, 1);
		u_chk.finish_test("backup load");

		// Console rewrites everything, then the host saves it
		for (int a = 0; a < 2048; a++) begin
			save_data[a] = 8'($urandom());
			@(posedge clk_sys);
			brm_addr  <= 11'(a);
			brm_wdata <= save_data[a];
			brm_we    <= 1'b1;
		end
		@(posedge clk_sys);
		brm_we  <= 1'b0;
		bk_save <= 1'b1;
		for (int s = 0; s < 4; s++) begin
			wait_request(1'b1, s);
			@(posedge clk_sys);
			sd_ack  <= 1'b1;
			bk_save <= 1'b0;
			for (int i = 0; i < 512; i++) begin
				@(posedge clk_sys);
				sd_buff_addr <= 9'(i);
				@(posedge clk_sys);
				@(negedge clk_sys);
				u_chk.check_value("sd_buff_din", sd_buff_din, save_data[s * 512 + i]);
			end
			@(posedge clk_sys);
			sd_ack <= 1'b0;
		end
		wait_idle();
		@(negedge clk_sys);
		u_chk.check_value("bk_reset pulses", u_chk.reset_pulses, 1);
		u_chk.finish_test("backup save");

		u_chk.report_counts();
		if (u_chk.total_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYC_LIMIT) begin
			$display("Run stopped after %0d cycles without finishing", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

endmodule

// ==== all.f ====
verilog/pce_io_pkg.sv
verilog/pad_mux.sv
verilog/mouse_reader.sv
verilog/audio_mixer.sv
verilog/backup_ram.sv
verilog/pce_io_top.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== Bender.yml ====
package:
  name: pce_io

sources:
  - verilog/pce_io_pkg.sv
  - verilog/pad_mux.sv
  - verilog/mouse_reader.sv
  - verilog/audio_mixer.sv
  - verilog/backup_ram.sv
  - verilog/pce_io_top.sv
  - target: test
    files:
      - dv/tb_checker.sv
      - dv/tb_top.sv
